/* src/vertex_job_macros.svh */
//////////////////////////////////////////////////////////////////////
// widths and queue depths of the vertex job control unit
// include wherever a size is needed, the package pulls it in too
//////////////////////////////////////////////////////////////////////

`ifndef VERTEX_JOB_MACROS_SVH
`define VERTEX_JOB_MACROS_SVH

// one element of a vertex array
`define VJ_VERTEX_BITS 32
`define VJ_LINE_VERTICES 8
`define VJ_LINE_BITS 256
// byte step from one line to the next
`define VJ_LINE_BYTES 32
`define VJ_ADDR_BITS 64
`define VJ_ID_BITS 16

// queue depths
`define VJ_CMD_DEPTH 4
`define VJ_VERTEX_DEPTH 16

`endif

/* src/vertex_job_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared vector types and the array tag of commands and data lines
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vertex_job_macros.svh"

package vertex_job_pkg;

	typedef logic [`VJ_VERTEX_BITS-1:0] vertex_word_t;
	typedef logic [`VJ_ID_BITS-1:0] vertex_id_t;
	typedef logic [31:0] vertex_count_t;
	// holds 0 up to a full line of vertices
	typedef logic [$clog2(`VJ_LINE_VERTICES+1)-1:0] line_count_t;
	typedef logic [`VJ_ADDR_BITS-1:0] addr_t;
	typedef logic [`VJ_LINE_BITS-1:0] cacheline_t;

	// which vertex array a command or a returned line belongs to
	typedef enum logic {
		inv_out_degree,
		inv_edges_idx
	} array_struct_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
//////////////////////////////////////////////////////////////////////
// synchronous queue, data_out is loaded on pop and valid follows
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             full,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);
	localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
	localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;

	assign full  = (count == FULL_COUNT);
	assign empty = (count == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= pop;
			if (push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// storage and output word
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
		if (pop)
			data_out <= mem[rd_ptr];
	end

	no_overflow: assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

`default_nettype wire

/* src/read_command_gen.sv */
//////////////////////////////////////////////////////////////////////
// splits a job into cachelines and issues two read commands per line
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "vertex_job_macros.svh"

module read_command_gen
	import vertex_job_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          wed_valid,
	input  vertex_count_t wed_num_vertices,
	input  addr_t         wed_out_degree_base,
	input  addr_t         wed_edges_idx_base,
	input  logic          line_done,
	output logic          job_start,
	output logic          cmd_push,
	output addr_t         cmd_address,
	output array_struct_t cmd_array,
	output line_count_t   cmd_size,
	output logic          busy
);

	typedef enum logic [1:0] {
		gen_idle,
		gen_send_degree,
		gen_send_edges,
		gen_wait_line
	} gen_state_t;

	gen_state_t state;
	addr_t out_degree_base;
	addr_t edges_idx_base;
	addr_t line_offset;
	vertex_count_t remaining;
	line_count_t line_size;
	logic last_line;

	// a line holds at most a full cacheline of vertices
	assign last_line = (remaining <= vertex_count_t'(`VJ_LINE_VERTICES));
	assign line_size = last_line ? line_count_t'(remaining) : line_count_t'(`VJ_LINE_VERTICES);
	assign busy = (state != gen_idle);

	//////////////////////////////////////////////////////////////////////
	// job state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= gen_idle;
			job_start <= 1'b0;
			cmd_push  <= 1'b0;
			remaining <= '0;
		end else begin
			job_start <= 1'b0;
			cmd_push  <= 1'b0;
			case (state)
				gen_idle: begin
					if (wed_valid) begin
						job_start <= 1'b1;
						remaining <= wed_num_vertices;
						// an empty job ends right here
						if (wed_num_vertices != '0)
							state <= gen_send_degree;
					end
				end
				gen_send_degree: begin
					cmd_push <= 1'b1;
					state    <= gen_send_edges;
				end
				gen_send_edges: begin
					cmd_push <= 1'b1;
					state    <= gen_wait_line;
				end
				gen_wait_line: begin
					if (line_done) begin
						remaining <= remaining - vertex_count_t'(line_size);
						state     <= last_line ? gen_idle : gen_send_degree;
					end
				end
				default: state <= gen_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// descriptor and command fields
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		case (state)
			gen_idle: begin
				out_degree_base <= wed_out_degree_base;
				edges_idx_base  <= wed_edges_idx_base;
				line_offset     <= '0;
			end
			gen_send_degree: begin
				cmd_address <= out_degree_base + line_offset;
				cmd_array   <= inv_out_degree;
				cmd_size    <= line_size;
			end
			gen_send_edges: begin
				cmd_address <= edges_idx_base + line_offset;
				cmd_array   <= inv_edges_idx;
				cmd_size    <= line_size;
			end
			gen_wait_line: begin
				if (line_done)
					line_offset <= line_offset + addr_t'(`VJ_LINE_BYTES);
			end
			default: line_offset <= '0;
		endcase
	end

	// a new descriptor must wait for the running job
	wed_while_busy: assert property (@(posedge clock) disable iff (!rstn) wed_valid |-> !busy);
	// the unpacker only finishes a line whose commands went out
	done_in_wait: assert property (@(posedge clock) disable iff (!rstn)
		line_done |-> state == gen_wait_line);

endmodule

`default_nettype wire

/* src/vertex_line_unpacker.sv */
//////////////////////////////////////////////////////////////////////
// collects the two data lines of a chunk, then shifts out one vertex
// per cycle with a running id into the vertex queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "vertex_job_macros.svh"

module vertex_line_unpacker
	import vertex_job_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          job_start,
	input  logic          read_data_valid,
	input  array_struct_t read_data_array,
	input  line_count_t   read_data_size,
	input  cacheline_t    read_data_line,
	input  logic          vertex_full,
	output logic          vertex_push,
	output vertex_id_t    vertex_id,
	output vertex_word_t  vertex_inv_out_degree,
	output vertex_word_t  vertex_inv_edges_idx,
	output logic          line_done
);

	cacheline_t out_degree_line;
	cacheline_t edges_idx_line;
	logic have_out_degree;
	logic have_edges_idx;
	line_count_t line_size;
	line_count_t shift_count;
	logic line_ready;

	assign line_ready  = have_out_degree && have_edges_idx;
	assign vertex_push = line_ready && !vertex_full;
	assign line_done   = vertex_push && (shift_count == line_size - 1'b1);

	// lowest word of each register is the next vertex
	assign vertex_inv_out_degree = out_degree_line[`VJ_VERTEX_BITS-1:0];
	assign vertex_inv_edges_idx  = edges_idx_line[`VJ_VERTEX_BITS-1:0];

	//////////////////////////////////////////////////////////////////////
	// arrival flags, shift count and id
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			have_out_degree <= 1'b0;
			have_edges_idx  <= 1'b0;
			shift_count     <= '0;
			vertex_id       <= '0;
		end else begin
			if (read_data_valid) begin
				case (read_data_array)
					inv_out_degree: have_out_degree <= 1'b1;
					inv_edges_idx:  have_edges_idx  <= 1'b1;
					default: ;
				endcase
			end
			if (vertex_push)
				shift_count <= shift_count + 1'b1;
			if (line_done) begin
				have_out_degree <= 1'b0;
				have_edges_idx  <= 1'b0;
				shift_count     <= '0;
			end
			// ids count on across lines, restart per job
			if (job_start)
				vertex_id <= '0;
			else if (vertex_push)
				vertex_id <= vertex_id + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// line registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (read_data_valid) begin
			line_size <= read_data_size;
			case (read_data_array)
				inv_out_degree: out_degree_line <= read_data_line;
				inv_edges_idx:  edges_idx_line  <= read_data_line;
				default: ;
			endcase
		end else if (vertex_push) begin
			out_degree_line <= out_degree_line >> `VJ_VERTEX_BITS;
			edges_idx_line  <= edges_idx_line >> `VJ_VERTEX_BITS;
		end
	end

	// memory side returns one line per tag per chunk
	no_extra_line: assert property (@(posedge clock) disable iff (!rstn)
		read_data_valid |->
			!((read_data_array == inv_out_degree) ? have_out_degree : have_edges_idx));

endmodule

`default_nettype wire

/* src/vertex_job_control.sv */
//////////////////////////////////////////////////////////////////////
// vertex job control top, command generator and unpacker feeding the
// read command queue and the vertex job queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "vertex_job_macros.svh"

module vertex_job_control
	import vertex_job_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          wed_valid,
	input  vertex_count_t wed_num_vertices,
	input  addr_t         wed_out_degree_base,
	input  addr_t         wed_edges_idx_base,
	input  logic          read_command_grant,
	input  logic          read_data_valid,
	input  array_struct_t read_data_array,
	input  line_count_t   read_data_size,
	input  cacheline_t    read_data_line,
	input  logic          vertex_request,
	output logic          read_command_request,
	output addr_t         read_command_address,
	output array_struct_t read_command_array,
	output line_count_t   read_command_size,
	output logic          vertex_ready,
	output logic          vertex_valid,
	output vertex_id_t    vertex_id,
	output vertex_word_t  vertex_inv_out_degree,
	output vertex_word_t  vertex_inv_edges_idx,
	output logic          busy
);

	localparam int CMD_BITS = $bits(addr_t) + $bits(array_struct_t) + $bits(line_count_t);
	localparam int VERTEX_BITS = $bits(vertex_id_t) + 2 * $bits(vertex_word_t);

	logic job_start;
	logic line_done;
	logic cmd_push;
	addr_t cmd_address;
	array_struct_t cmd_array;
	line_count_t cmd_size;
	logic [CMD_BITS-1:0] cmd_head;
	logic cmd_head_array;
	logic cmd_pop;
	logic cmd_valid;
	logic cmd_empty;
	logic cmd_slot_held;
	logic unpack_push;
	vertex_id_t unpack_id;
	vertex_word_t unpack_out_degree;
	vertex_word_t unpack_edges_idx;
	logic [VERTEX_BITS-1:0] vertex_head;
	logic vertex_full;
	logic vertex_empty;

	read_command_gen u_read_command_gen (
		.clock              (clock),
		.rstn               (rstn),
		.wed_valid          (wed_valid),
		.wed_num_vertices   (wed_num_vertices),
		.wed_out_degree_base(wed_out_degree_base),
		.wed_edges_idx_base (wed_edges_idx_base),
		.line_done          (line_done),
		.job_start          (job_start),
		.cmd_push           (cmd_push),
		.cmd_address        (cmd_address),
		.cmd_array          (cmd_array),
		.cmd_size           (cmd_size),
		.busy               (busy)
	);

	//////////////////////////////////////////////////////////////////////
	// read command queue
	//////////////////////////////////////////////////////////////////////

	// the head word sits in data_out until granted, refill when free
	assign read_command_request = cmd_valid || cmd_slot_held;
	assign cmd_pop = !cmd_empty && (!read_command_request || read_command_grant);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmd_slot_held <= 1'b0;
		else
			cmd_slot_held <= read_command_request && !read_command_grant;
	end

	sync_fifo #(
		.WIDTH(CMD_BITS),
		.DEPTH(`VJ_CMD_DEPTH)
	) u_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in ({cmd_address, cmd_array, cmd_size}),
		.pop     (cmd_pop),
		.data_out(cmd_head),
		.valid   (cmd_valid),
		.full    (),
		.empty   (cmd_empty)
	);

	assign {read_command_address, cmd_head_array, read_command_size} = cmd_head;
	assign read_command_array = array_struct_t'(cmd_head_array);

	grant_with_request: assert property (@(posedge clock) disable iff (!rstn)
		read_command_grant |-> read_command_request);

	//////////////////////////////////////////////////////////////////////
	// unpacker and vertex job queue
	//////////////////////////////////////////////////////////////////////

	vertex_line_unpacker u_vertex_line_unpacker (
		.clock                (clock),
		.rstn                 (rstn),
		.job_start            (job_start),
		.read_data_valid      (read_data_valid),
		.read_data_array      (read_data_array),
		.read_data_size       (read_data_size),
		.read_data_line       (read_data_line),
		.vertex_full          (vertex_full),
		.vertex_push          (unpack_push),
		.vertex_id            (unpack_id),
		.vertex_inv_out_degree(unpack_out_degree),
		.vertex_inv_edges_idx (unpack_edges_idx),
		.line_done            (line_done)
	);

	sync_fifo #(
		.WIDTH(VERTEX_BITS),
		.DEPTH(`VJ_VERTEX_DEPTH)
	) u_vertex_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (unpack_push),
		.data_in ({unpack_id, unpack_out_degree, unpack_edges_idx}),
		.pop     (vertex_request),
		.data_out(vertex_head),
		.valid   (vertex_valid),
		.full    (vertex_full),
		.empty   (vertex_empty)
	);

	assign {vertex_id, vertex_inv_out_degree, vertex_inv_edges_idx} = vertex_head;
	assign vertex_ready = !vertex_empty;

endmodule

`default_nettype wire

/* tb/tb_vertex_job_control.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the vertex job control top, runs a table of jobs
// against a memory model and a random consumer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "vertex_job_macros.svh"

module tb_vertex_job_control
	import vertex_job_pkg::*;
();

	localparam int NUM_JOBS = 7;
	localparam logic [31:0] OD_FILL = 32'h0d0d_0000;
	localparam logic [31:0] EI_FILL = 32'he1e1_0000;

	logic clock;
	logic rstn;
	logic wed_valid;
	vertex_count_t wed_num_vertices;
	addr_t wed_out_degree_base;
	addr_t wed_edges_idx_base;
	logic read_command_grant;
	logic read_data_valid;
	array_struct_t read_data_array;
	line_count_t read_data_size;
	cacheline_t read_data_line;
	logic vertex_request;
	logic read_command_request;
	addr_t read_command_address;
	array_struct_t read_command_array;
	line_count_t read_command_size;
	logic vertex_ready;
	logic vertex_valid;
	vertex_id_t vertex_id;
	vertex_word_t vertex_inv_out_degree;
	vertex_word_t vertex_inv_edges_idx;
	logic busy;

	// job table of vertex count, two bases and consumer hold-off cycles
	int job_count [NUM_JOBS];
	addr_t job_od_base [NUM_JOBS];
	addr_t job_ei_base [NUM_JOBS];
	int job_hold [NUM_JOBS];

	int cur_count;
	addr_t cur_od_base;
	addr_t cur_ei_base;
	int hold_cycles;
	int cmd_index;
	int lines_returned;
	int received;
	int grant_delay;
	int return_delay;
	int cycle_count;
	int cycle_limit;
	logic running;
	logic requested_last;
	logic busy_last;
	logic [31:0] lfsr_state;

	// commands of the chunk in flight and lines waiting to return
	addr_t pend_addr [$];
	array_struct_t pend_tag [$];
	line_count_t pend_size [$];
	addr_t ret_addr [$];
	array_struct_t ret_tag [$];
	line_count_t ret_size [$];

	vertex_job_control u_vertex_job_control (
		.clock                (clock),
		.rstn                 (rstn),
		.wed_valid            (wed_valid),
		.wed_num_vertices     (wed_num_vertices),
		.wed_out_degree_base  (wed_out_degree_base),
		.wed_edges_idx_base   (wed_edges_idx_base),
		.read_command_grant   (read_command_grant),
		.read_data_valid      (read_data_valid),
		.read_data_array      (read_data_array),
		.read_data_size       (read_data_size),
		.read_data_line       (read_data_line),
		.vertex_request       (vertex_request),
		.read_command_request (read_command_request),
		.read_command_address (read_command_address),
		.read_command_array   (read_command_array),
		.read_command_size    (read_command_size),
		.vertex_ready         (vertex_ready),
		.vertex_valid         (vertex_valid),
		.vertex_id            (vertex_id),
		.vertex_inv_out_degree(vertex_inv_out_degree),
		.vertex_inv_edges_idx (vertex_inv_edges_idx),
		.busy                 (busy)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic stop_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at %0t ns", $time);
	endtask

	task automatic compare_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			stop_with_failure();
		end
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic next_random_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic int random_delay();
		int d;
		d = next_random_bit() ? 2 : 0;
		d = d + (next_random_bit() ? 1 : 0);
		return d;
	endfunction

	// memory content as a function of the whole byte address
	function automatic vertex_word_t array_word(input addr_t address, input array_struct_t tag);
		vertex_word_t fill;
		fill = (tag == inv_out_degree) ? OD_FILL : EI_FILL;
		return address[63:32] ^ address[31:0] ^ fill;
	endfunction

	function automatic cacheline_t build_line(input addr_t address, input array_struct_t tag);
		cacheline_t data;
		data = '0;
		for (int k = 0; k < `VJ_LINE_VERTICES; k++)
			data[k*`VJ_VERTEX_BITS +: `VJ_VERTEX_BITS] = array_word(address + addr_t'(4 * k), tag);
		return data;
	endfunction

	function automatic int line_total(input int count);
		return (count + `VJ_LINE_VERTICES - 1) / `VJ_LINE_VERTICES;
	endfunction

	task automatic set_job(input int j, input int count, input addr_t od_base,
			input addr_t ei_base, input int hold);
		job_count[j] = count;
		job_od_base[j] = od_base;
		job_ei_base[j] = ei_base;
		job_hold[j] = hold;
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory side and consumer models
	//////////////////////////////////////////////////////////////////////

	task automatic take_command();
		int line_num;
		int left;
		addr_t base;
		array_struct_t tag;
		logic swap;
		if (cmd_index >= 2 * line_total(cur_count)) begin
			$display("read command granted at %0t ns after the job's last line", $time);
			stop_with_failure();
		end else begin
			line_num = cmd_index / 2;
			tag = (cmd_index % 2 == 0) ? inv_out_degree : inv_edges_idx;
			base = (tag == inv_out_degree) ? cur_od_base : cur_ei_base;
			left = cur_count - line_num * `VJ_LINE_VERTICES;
			if (left > `VJ_LINE_VERTICES)
				left = `VJ_LINE_VERTICES;
			compare_value("read_command_address", read_command_address,
				base + addr_t'(line_num * `VJ_LINE_BYTES));
			compare_value("read_command_array", 64'(read_command_array), 64'(tag));
			compare_value("read_command_size", 64'(read_command_size), 64'(left));
			pend_addr.push_back(read_command_address);
			pend_tag.push_back(read_command_array);
			pend_size.push_back(read_command_size);
			cmd_index++;
			// a complete chunk goes to the return side, reversed on a set bit
			if (pend_addr.size() == 2) begin
				swap = next_random_bit();
				for (int i = 0; i < 2; i++) begin
					int idx;
					idx = swap ? 1 - i : i;
					ret_addr.push_back(pend_addr[idx]);
					ret_tag.push_back(pend_tag[idx]);
					ret_size.push_back(pend_size[idx]);
				end
				pend_addr.delete();
				pend_tag.delete();
				pend_size.delete();
			end
		end
	endtask

	task automatic grant_command();
		read_command_grant = 1'b0;
		if (read_command_request) begin
			if (grant_delay == 0) begin
				take_command();
				read_command_grant = 1'b1;
				grant_delay = random_delay();
			end else begin
				grant_delay--;
			end
		end
	endtask

	task automatic return_line();
		read_data_valid = 1'b0;
		if (ret_addr.size() != 0) begin
			if (return_delay == 0) begin
				read_data_valid = 1'b1;
				read_data_array = ret_tag[0];
				read_data_size = ret_size[0];
				read_data_line = build_line(ret_addr[0], ret_tag[0]);
				void'(ret_addr.pop_front());
				void'(ret_tag.pop_front());
				void'(ret_size.pop_front());
				lines_returned++;
				return_delay = random_delay();
			end else begin
				return_delay--;
			end
		end
	endtask

	task automatic check_vertex();
		addr_t offset;
		compare_value("vertex_valid", 64'(vertex_valid), 64'(requested_last));
		if (vertex_valid && received >= cur_count) begin
			$display("extra vertex at %0t ns beyond the job's %0d vertices", $time, cur_count);
			stop_with_failure();
		end else if (vertex_valid) begin
			offset = addr_t'(4 * received);
			compare_value("vertex_id", 64'(vertex_id), 64'(received));
			compare_value("vertex_inv_out_degree", 64'(vertex_inv_out_degree),
				64'(array_word(cur_od_base + offset, inv_out_degree)));
			compare_value("vertex_inv_edges_idx", 64'(vertex_inv_edges_idx),
				64'(array_word(cur_ei_base + offset, inv_edges_idx)));
			received++;
		end
	endtask

	task automatic consume();
		vertex_request = 1'b0;
		requested_last = 1'b0;
		if (hold_cycles > 0) begin
			hold_cycles--;
		end else if (vertex_ready && next_random_bit()) begin
			vertex_request = 1'b1;
			requested_last = 1'b1;
		end
	endtask

	// one clock with all models acting 1 ns after the edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			stop_with_failure();
		end else if (running) begin
			check_vertex();
			// every line is unpacked once busy drops
			if (busy_last && !busy) begin
				compare_value("lines_returned", 64'(lines_returned),
					64'(2 * line_total(cur_count)));
				if (cur_count - received > `VJ_VERTEX_DEPTH) begin
					$display("busy fell at %0t ns with %0d vertices outstanding, more than %s",
						$time, cur_count - received, "the vertex queue holds");
					stop_with_failure();
				end
			end
			busy_last = busy;
			consume();
			return_line();
			grant_command();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// job sequence
	//////////////////////////////////////////////////////////////////////

	task automatic run_job(input int j);
		cur_count = job_count[j];
		cur_od_base = job_od_base[j];
		cur_ei_base = job_ei_base[j];
		hold_cycles = job_hold[j];
		cmd_index = 0;
		lines_returned = 0;
		received = 0;
		next_cycle();
		wed_valid = 1'b1;
		wed_num_vertices = vertex_count_t'(cur_count);
		wed_out_degree_base = cur_od_base;
		wed_edges_idx_base = cur_ei_base;
		next_cycle();
		wed_valid = 1'b0;
		// until the job ends and the vertex queue is drained
		while (busy || vertex_ready)
			next_cycle();
		repeat (8) next_cycle();
		compare_value("read_command_grant count", 64'(cmd_index), 64'(2 * line_total(cur_count)));
		compare_value("lines_returned", 64'(lines_returned), 64'(2 * line_total(cur_count)));
		compare_value("vertex count", 64'(received), 64'(cur_count));
		compare_value("vertex_ready", 64'(vertex_ready), 64'(0));
		compare_value("read_command_request", 64'(read_command_request), 64'(0));
	endtask

	initial begin
		int total;
		set_job(0, 0, 64'h0000_0000_0001_0000, 64'h0000_0000_0002_0000, 0);
		set_job(1, 1, 64'h0000_0001_0000_0100, 64'h0000_0002_0000_0200, 0);
		set_job(2, 7, 64'h0000_0000_3000_0040, 64'h0000_0000_4000_0080, 0);
		set_job(3, 8, 64'h0000_0000_0fff_ffe0, 64'h0000_0000_5555_5000, 0);
		set_job(4, 9, 64'h0000_0007_1234_5600, 64'h0000_0000_0abc_de20, 0);
		set_job(5, 20, 64'h0000_0000_6000_0000, 64'h0000_0000_7000_0100, 30);
		// long hold-off fills the vertex queue and the base crosses 4 GiB
		set_job(6, 40, 64'h0000_0003_ffff_ff80, 64'h0000_0000_8000_0000, 80);
		total = 0;
		for (int j = 0; j < NUM_JOBS; j++)
			total += job_count[j];
		cycle_limit = 40 * total + 200;
		cycle_count = 0;
		lfsr_state = 32'ha944_496f;
		running = 1'b0;
		requested_last = 1'b0;
		busy_last = 1'b0;
		grant_delay = 0;
		return_delay = 0;
		cur_count = 0;
		cur_od_base = '0;
		cur_ei_base = '0;
		hold_cycles = 0;
		cmd_index = 0;
		lines_returned = 0;
		received = 0;
		rstn = 1'b0;
		wed_valid = 1'b0;
		wed_num_vertices = '0;
		wed_out_degree_base = '0;
		wed_edges_idx_base = '0;
		read_command_grant = 1'b0;
		read_data_valid = 1'b0;
		read_data_array = inv_out_degree;
		read_data_size = '0;
		read_data_line = '0;
		vertex_request = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		rstn = 1'b1;
		compare_value("read_command_request", 64'(read_command_request), 64'(0));
		compare_value("vertex_valid", 64'(vertex_valid), 64'(0));
		compare_value("vertex_ready", 64'(vertex_ready), 64'(0));
		compare_value("busy", 64'(busy), 64'(0));
		running = 1'b1;
		for (int j = 0; j < NUM_JOBS; j++)
			run_job(j);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vertex_job.f */
+incdir+src
src/vertex_job_pkg.sv
src/sync_fifo.sv
src/read_command_gen.sv
src/vertex_line_unpacker.sv
src/vertex_job_control.sv
tb/tb_vertex_job_control.sv

/* Makefile */
# Verilator build and run of the vertex job control testbench

TOP = tb_vertex_job_control

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f vertex_job.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
